//--- bench/mem_access_asserts.sv
// Concurrent assertions on write credits, reset values and init reset of the access unit
`timescale 1ns/100ps
`include "bmd_settings.svh"

module mem_access_asserts (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_valid_i,
    input  logic wr_credit_i,
    input  logic init_rst_i,
    input  logic mwr_start_i,
    input  logic mrd_start_i
);

    int in_flight;                  // Accepted writes not yet credited
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(wr_valid_i) - int'(wr_credit_i);
        end
    end

    // Oldest write credited three cycles after its acceptance or the previous credit
    credit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight > 0 |-> ##[0:2] wr_credit_i)
        else begin
            fail_count++;
            $error("oldest write in flight not credited within three cycles");
        end

    credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
        wr_credit_i |-> in_flight > 0)
        else begin
            fail_count++;
            $error("credit returned with no write in flight");
        end

    credit_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wr_credit_i |=> !wr_credit_i)
        else begin
            fail_count++;
            $error("credit pulse longer than one cycle");
        end

    init_holds_start: assert property (@(posedge clk) disable iff (!rst_n)
        init_rst_i |-> !mwr_start_i && !mrd_start_i)
        else begin
            fail_count++;
            $error("start bit set while init reset is active");
        end

    reset_values: assert property (@(posedge clk)
        !rst_n |=> !wr_credit_i && !init_rst_i && !mwr_start_i && !mrd_start_i)
        else begin
            fail_count++;
            $error("control output high after reset");
        end

endmodule

//--- bench/mem_access_checker.sv
// Register map model with per-cycle read data and post-commit control output comparison
`timescale 1ns/100ps
`include "bmd_settings.svh"

module mem_access_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_valid_i,
    input  bmd_access_pkg::reg_addr_t  wr_addr_i,
    input  bmd_access_pkg::byte_en_t   wr_be_i,
    input  bmd_access_pkg::data_word_t wr_data_i,
    input  logic                       wr_credit_i,
    input  bmd_access_pkg::reg_addr_t  rd_addr_i,
    input  bmd_access_pkg::byte_en_t   rd_be_i,
    input  bmd_access_pkg::data_word_t rd_data_i,
    input  logic                       mwr_done_i,
    input  logic                       mrd_done_i,
    input  logic                       init_rst_i,
    input  logic                       mwr_start_i,
    input  logic                       mrd_start_i,
    input  bmd_access_pkg::data_word_t mwr_addr_i, mwr_len_i, mwr_count_i, mwr_data_i,
    input  bmd_access_pkg::data_word_t mrd_addr_i, mrd_len_i, mrd_count_i,
    output int                         rd_errors_o,
    output int                         ctrl_errors_o,
    output int                         proto_errors_o
);

    import bmd_reg_pkg::*;
    import bmd_access_pkg::*;

    // Accepted writes waiting for their credit, oldest first
    reg_addr_t  pend_addr [$];
    byte_en_t   pend_be [$];
    data_word_t pend_data [$];

    logic       m_init;
    logic       m_mwr_start;
    logic       m_mwr_done;
    logic       m_mrd_start;
    logic       m_mrd_done;
    data_word_t m_desc [2:8];           // WDMA_ADDR up to RDMA_COUNT

    logic       ctrl_due;
    logic       orphan;
    data_word_t exp_rd;
    int         rd_errors = 0;
    int         ctrl_errors = 0;
    int         proto_errors = 0;

    assign rd_errors_o    = rd_errors;
    assign ctrl_errors_o  = ctrl_errors;
    assign proto_errors_o = proto_errors;

    // --------------------
    // Register model
    // --------------------

    function automatic data_word_t model_read(input reg_addr_t addr);
        data_word_t word;
        word = '0;
        if (addr == REG_DCSR) begin
            word[DCSR_VER_MSB:DCSR_VER_LSB] = `BMD_VERSION;
            word[DCSR_INIT_RST] = m_init;
        end else if (addr == REG_DDMACR) begin
            word[DDMACR_MWR_START] = m_mwr_start;
            word[DDMACR_MWR_DONE]  = m_mwr_done;
            word[DDMACR_MRD_START] = m_mrd_start;
            word[DDMACR_MRD_DONE]  = m_mrd_done;
        end else if (addr < `BMD_REG_COUNT) begin
            word = m_desc[addr];
        end
        return word;                    // Unmapped stays zero
    endfunction

    // Host lane j holds stored byte j, counted from the top byte down
    function automatic data_word_t host_lanes(input data_word_t word, input byte_en_t be);
        logic [7:0] lanes [4];
        for (int j = 0; j < 4; j++) begin
            lanes[j] = be[j] ? word[8*j +: 8] : 8'h00;
        end
        return {lanes[0], lanes[1], lanes[2], lanes[3]};
    endfunction

    task automatic apply_write(input reg_addr_t addr, input byte_en_t be, input data_word_t data);
        data_word_t word;
        word = model_read(addr);
        for (int j = 0; j < 4; j++) begin
            if (be[j]) begin
                word[8*j +: 8] = data[31-8*j -: 8];
            end
        end
        if (addr == REG_DCSR) begin
            m_init = word[DCSR_INIT_RST];
        end else if (addr == REG_DDMACR) begin
            m_mwr_start = word[DDMACR_MWR_START];
            m_mrd_start = word[DDMACR_MRD_START];
        end else if (addr < `BMD_REG_COUNT) begin
            m_desc[addr] = word;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            m_init = 1'b0;
            m_mwr_start = 1'b0;
            m_mwr_done = 1'b0;
            m_mrd_start = 1'b0;
            m_mrd_done = 1'b0;
            for (int a = 2; a <= 8; a++) begin
                m_desc[a] = '0;
            end
            pend_addr.delete();
            pend_be.delete();
            pend_data.delete();
            ctrl_due = 1'b1;            // Reset values checked once
            orphan = 1'b0;
        end else begin
            ctrl_due = wr_credit_i;
            orphan = 1'b0;
            if (wr_valid_i) begin
                pend_addr.push_back(wr_addr_i);
                pend_be.push_back(wr_be_i);
                pend_data.push_back(wr_data_i);
            end
            if (wr_credit_i && pend_addr.size() == 0) begin
                orphan = 1'b1;
            end else if (wr_credit_i) begin
                apply_write(pend_addr.pop_front(), pend_be.pop_front(), pend_data.pop_front());
            end
            if (mwr_done_i) m_mwr_done = 1'b1;
            if (mrd_done_i) m_mrd_done = 1'b1;
            if (m_init) begin           // Engines held idle
                m_mwr_start = 1'b0;
                m_mwr_done = 1'b0;
                m_mrd_start = 1'b0;
                m_mrd_done = 1'b0;
            end
        end
    end

    // --------------------
    // Comparison
    // --------------------

    task automatic compare_ctrl(input string name, input data_word_t exp, input data_word_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            ctrl_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            exp_rd = host_lanes(model_read(rd_addr_i), rd_be_i);
            if (rd_data_i !== exp_rd) begin
                $display("Mismatch in read_data (addr %0d, be %b): expected %h, actual %h",
                         rd_addr_i, rd_be_i, exp_rd, rd_data_i);
                rd_errors++;
            end
            if (orphan) begin
                $display("Error: the DUT returned a credit with no write outstanding");
                proto_errors++;
            end
            if (ctrl_due) begin
                compare_ctrl("init_rst", data_word_t'(m_init), data_word_t'(init_rst_i));
                compare_ctrl("mwr_start", data_word_t'(m_mwr_start), data_word_t'(mwr_start_i));
                compare_ctrl("mrd_start", data_word_t'(m_mrd_start), data_word_t'(mrd_start_i));
                compare_ctrl("mwr_addr", m_desc[REG_WDMA_ADDR], mwr_addr_i);
                compare_ctrl("mwr_len", m_desc[REG_WDMA_LEN], mwr_len_i);
                compare_ctrl("mwr_count", m_desc[REG_WDMA_COUNT], mwr_count_i);
                compare_ctrl("mwr_data", m_desc[REG_WDMA_PATTERN], mwr_data_i);
                compare_ctrl("mrd_addr", m_desc[REG_RDMA_ADDR], mrd_addr_i);
                compare_ctrl("mrd_len", m_desc[REG_RDMA_LEN], mrd_len_i);
                compare_ctrl("mrd_count", m_desc[REG_RDMA_COUNT], mrd_count_i);
            end
        end
    end

endmodule

//--- bench/tb_mem_access.sv
// Testbench top with clock, reset, seeded random host traffic, checker and closing report
`timescale 1ns/100ps
`include "bmd_settings.svh"

module tb_mem_access;

    import bmd_reg_pkg::*;
    import bmd_access_pkg::*;

    localparam int NUM_WRITES = 300;
    localparam int WAIT_LIMIT = 40;     // Cycles per wait

    logic       clk;
    logic       rst_n;
    logic       wr_valid;
    reg_addr_t  wr_addr;
    byte_en_t   wr_be;
    data_word_t wr_data;
    logic       wr_credit;
    reg_addr_t  rd_addr;
    byte_en_t   rd_be;
    data_word_t rd_data;
    logic       mwr_done;
    logic       mrd_done;
    logic       init_rst;
    logic       mwr_start;
    logic       mrd_start;
    data_word_t mwr_addr, mwr_len, mwr_count, mwr_data;
    data_word_t mrd_addr, mrd_len, mrd_count;

    int credits;
    int waited;
    int timeouts;
    int rd_errors;
    int ctrl_errors;
    int proto_errors;
    int assert_errors;

    bmd_mem_access DUT (
        .clk(clk), .rst_n(rst_n),
        .wr_valid_i(wr_valid), .wr_addr_i(wr_addr), .wr_be_i(wr_be), .wr_data_i(wr_data),
        .wr_credit_o(wr_credit), .rd_addr_i(rd_addr), .rd_be_i(rd_be), .rd_data_o(rd_data),
        .mwr_done_i(mwr_done), .mrd_done_i(mrd_done), .init_rst_o(init_rst),
        .mwr_start_o(mwr_start), .mwr_addr_o(mwr_addr), .mwr_len_o(mwr_len),
        .mwr_count_o(mwr_count), .mwr_data_o(mwr_data), .mrd_start_o(mrd_start),
        .mrd_addr_o(mrd_addr), .mrd_len_o(mrd_len), .mrd_count_o(mrd_count)
    );

    mem_access_checker u_checker (
        .clk(clk), .rst_n(rst_n),
        .wr_valid_i(wr_valid), .wr_addr_i(wr_addr), .wr_be_i(wr_be), .wr_data_i(wr_data),
        .wr_credit_i(wr_credit), .rd_addr_i(rd_addr), .rd_be_i(rd_be), .rd_data_i(rd_data),
        .mwr_done_i(mwr_done), .mrd_done_i(mrd_done), .init_rst_i(init_rst),
        .mwr_start_i(mwr_start), .mwr_addr_i(mwr_addr), .mwr_len_i(mwr_len),
        .mwr_count_i(mwr_count), .mwr_data_i(mwr_data), .mrd_start_i(mrd_start),
        .mrd_addr_i(mrd_addr), .mrd_len_i(mrd_len), .mrd_count_i(mrd_count),
        .rd_errors_o(rd_errors), .ctrl_errors_o(ctrl_errors), .proto_errors_o(proto_errors)
    );

    bind bmd_mem_access mem_access_asserts u_asserts (
        .clk(clk), .rst_n(rst_n), .wr_valid_i(wr_valid_i), .wr_credit_i(wr_credit_o),
        .init_rst_i(init_rst_o), .mwr_start_i(mwr_start_o), .mrd_start_i(mrd_start_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Stimulus
    // --------------------

    // Mostly mapped words, DDMACR favoured so start bits move
    function automatic reg_addr_t pick_addr();
        int sel;
        sel = $urandom % 16;
        if (sel == 0) begin
            return reg_addr_t'(`BMD_REG_COUNT + $urandom % ((1 << `BMD_ADDR_W) - `BMD_REG_COUNT));
        end else if (sel < 3) begin
            return reg_addr_t'(REG_DDMACR);
        end
        return reg_addr_t'($urandom % `BMD_REG_COUNT);
    endfunction

    // One clock of host traffic, with a random read and random done pulses
    task automatic drive_cycle(input logic do_write);
        @(posedge clk);
        credits += int'(wr_credit);     // Credit seen on this edge
        rd_addr  <= pick_addr();
        rd_be    <= byte_en_t'($urandom);
        mwr_done <= ($urandom % 16) == 0;
        mrd_done <= ($urandom % 16) == 0;
        wr_valid <= do_write;
        if (do_write) begin
            wr_addr <= pick_addr();
            wr_be   <= byte_en_t'($urandom);
            wr_data <= $urandom;
            credits--;
        end
    endtask

    initial begin
        void'($urandom(76));
        rst_n    = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_be    = '0;
        wr_data  = '0;
        rd_addr  = '0;
        rd_be    = '1;
        mwr_done = 1'b0;
        mrd_done = 1'b0;
        timeouts = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        credits = `BMD_WR_CREDITS;

        for (int n = 0; n < NUM_WRITES; n++) begin
            for (waited = 0; credits == 0 && waited < WAIT_LIMIT; waited++) begin
                drive_cycle(1'b0);
            end
            if (credits == 0) begin
                $display("Error: no write credit came back within %0d cycles", WAIT_LIMIT);
                timeouts++;
                break;
            end
            drive_cycle(1'b1);
            repeat ($urandom % 4) drive_cycle(1'b0);   // Zero gaps fill the queue
        end

        // Drain the queue
        for (waited = 0; credits < `BMD_WR_CREDITS && waited < WAIT_LIMIT; waited++) begin
            drive_cycle(1'b0);
        end
        if (credits != `BMD_WR_CREDITS) begin
            $display("Error: %0d credits still missing after the last write",
                     `BMD_WR_CREDITS - credits);
            timeouts++;
        end
        repeat (4) drive_cycle(1'b0);

        assert_errors = DUT.u_asserts.fail_count;
        $display("Errors: read %0d, control %0d, protocol %0d, timeout %0d, assertion %0d",
                 rd_errors, ctrl_errors, proto_errors, timeouts, assert_errors);
        if (rd_errors + ctrl_errors + proto_errors + timeouts + assert_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- include/bmd_settings.svh
// Width, register count, write queue depth and version macros of the access unit
`ifndef BMD_SETTINGS_SVH
`define BMD_SETTINGS_SVH

// --------------------
// Datapath widths
// --------------------

// Host data word in bits
`define BMD_DATA_W      32

// One enable per payload byte
`define BMD_BE_W        4

// Word address into the register aperture
`define BMD_ADDR_W      7

// --------------------
// Register block
// --------------------

// Mapped words, REG_DCSR up to REG_RDMA_COUNT
`define BMD_REG_COUNT   9

// Top byte of DCSR
`define BMD_VERSION     8'h02

// Write queue entries, equal to the host credits after reset
`define BMD_WR_CREDITS  2

`endif

//--- rtl/bmd_access_pkg.sv
// Data, byte-enable and address types and write sequencer state enum of the host port
`include "bmd_settings.svh"

package bmd_access_pkg;

    // --------------------
    // Host port types
    // --------------------

    typedef logic [`BMD_DATA_W-1:0] data_word_t;    // One register word
    typedef logic [`BMD_BE_W-1:0]   byte_en_t;      // Bit k enables stored byte k
    typedef logic [`BMD_ADDR_W-1:0] reg_addr_t;     // Word address

    // Bits per byte lane
    localparam int BYTE_W = 8;

    // --------------------
    // Write sequencer
    // --------------------

    // One write takes FETCH, MERGE and the commit cycle spent in IDLE
    typedef enum logic [1:0] {
        WR_IDLE,    // Commit of the previous write, if any
        WR_FETCH,   // Current word of the head entry read
        WR_MERGE    // Enabled payload bytes merged in
    } wr_state_e;

endpackage

//--- rtl/bmd_ctrl_regs.sv
// DMA descriptor, DCSR and DDMACR register block with one write port and two read ports
`timescale 1ns/100ps
`include "bmd_settings.svh"

module bmd_ctrl_regs (
    input  logic                      clk,
    input  logic                      rst_n,

    // Commit port from the host port
    input  logic                      commit_en_i,
    input  bmd_access_pkg::reg_addr_t commit_addr_i,
    input  bmd_access_pkg::data_word_t commit_data_i,

    // Read ports
    input  bmd_access_pkg::reg_addr_t fetch_addr_i,     // Read-modify-write fetch
    output bmd_access_pkg::data_word_t fetch_data_o,
    input  bmd_access_pkg::reg_addr_t rd_addr_i,        // Host read
    output bmd_access_pkg::data_word_t rd_raw_o,

    // DMA engine status
    input  logic                      mwr_done_i,
    input  logic                      mrd_done_i,

    // Control and descriptor outputs
    output logic                      init_rst_o,
    output logic                      mwr_start_o,
    output bmd_access_pkg::data_word_t mwr_addr_o,
    output bmd_access_pkg::data_word_t mwr_len_o,
    output bmd_access_pkg::data_word_t mwr_count_o,
    output bmd_access_pkg::data_word_t mwr_data_o,
    output logic                      mrd_start_o,
    output bmd_access_pkg::data_word_t mrd_addr_o,
    output bmd_access_pkg::data_word_t mrd_len_o,
    output bmd_access_pkg::data_word_t mrd_count_o
);

    import bmd_reg_pkg::*;
    import bmd_access_pkg::*;

    logic       init_rst_q;
    logic       init_rst_d;
    logic       mwr_start_q;
    logic       mwr_done_q;
    logic       mrd_start_q;
    logic       mrd_done_q;

    data_word_t wdma_addr_q;
    data_word_t wdma_len_q;
    data_word_t wdma_count_q;
    data_word_t wdma_pattern_q;
    data_word_t rdma_addr_q;
    data_word_t rdma_len_q;
    data_word_t rdma_count_q;

    logic       wr_hit;
    reg_addr_e  commit_reg;

    // --------------------
    // Write decode
    // --------------------

    assign wr_hit     = commit_en_i && (commit_addr_i < `BMD_REG_COUNT); // Unmapped dropped
    assign commit_reg = reg_addr_e'(commit_addr_i);

    // Init reset takes effect on the same edge as its DCSR write
    assign init_rst_d = (wr_hit && commit_reg == REG_DCSR) ?
                        commit_data_i[DCSR_INIT_RST] : init_rst_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_q  <= 1'b0;
            mwr_start_q <= 1'b0;
            mwr_done_q  <= 1'b0;
            mrd_start_q <= 1'b0;
            mrd_done_q  <= 1'b0;
        end else begin
            init_rst_q <= init_rst_d;
            if (init_rst_d) begin                       // Engines held idle
                mwr_start_q <= 1'b0;
                mwr_done_q  <= 1'b0;
                mrd_start_q <= 1'b0;
                mrd_done_q  <= 1'b0;
            end else begin
                if (wr_hit && commit_reg == REG_DDMACR) begin
                    mwr_start_q <= commit_data_i[DDMACR_MWR_START];
                    mrd_start_q <= commit_data_i[DDMACR_MRD_START];
                end
                if (mwr_done_i) begin
                    mwr_done_q <= 1'b1;                 // Sticky until init reset
                end
                if (mrd_done_i) begin
                    mrd_done_q <= 1'b1;
                end
            end
        end
    end

    // Descriptor words
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wdma_addr_q    <= '0;
            wdma_len_q     <= '0;
            wdma_count_q   <= '0;
            wdma_pattern_q <= '0;
            rdma_addr_q    <= '0;
            rdma_len_q     <= '0;
            rdma_count_q   <= '0;
        end else if (wr_hit) begin
            case (commit_reg)
                REG_WDMA_ADDR:    wdma_addr_q    <= commit_data_i;
                REG_WDMA_LEN:     wdma_len_q     <= commit_data_i;
                REG_WDMA_COUNT:   wdma_count_q   <= commit_data_i;
                REG_WDMA_PATTERN: wdma_pattern_q <= commit_data_i;
                REG_RDMA_ADDR:    rdma_addr_q    <= commit_data_i;
                REG_RDMA_LEN:     rdma_len_q     <= commit_data_i;
                REG_RDMA_COUNT:   rdma_count_q   <= commit_data_i;
                default: ;                              // DCSR and DDMACR above
            endcase
        end
    end

    // --------------------
    // Read ports
    // --------------------

    function automatic data_word_t read_word(input reg_addr_t addr);
        data_word_t word;
        word = '0;
        case (reg_addr_e'(addr))
            REG_DCSR: begin
                word[DCSR_VER_MSB:DCSR_VER_LSB] = `BMD_VERSION;
                word[DCSR_INIT_RST]             = init_rst_q;
            end
            REG_DDMACR: begin
                word[DDMACR_MWR_START] = mwr_start_q;
                word[DDMACR_MWR_DONE]  = mwr_done_q;
                word[DDMACR_MRD_START] = mrd_start_q;
                word[DDMACR_MRD_DONE]  = mrd_done_q;
            end
            REG_WDMA_ADDR:    word = wdma_addr_q;
            REG_WDMA_LEN:     word = wdma_len_q;
            REG_WDMA_COUNT:   word = wdma_count_q;
            REG_WDMA_PATTERN: word = wdma_pattern_q;
            REG_RDMA_ADDR:    word = rdma_addr_q;
            REG_RDMA_LEN:     word = rdma_len_q;
            REG_RDMA_COUNT:   word = rdma_count_q;
            default:          word = '0;                // Unmapped reads zero
        endcase
        return word;
    endfunction

    always_comb begin
        fetch_data_o = read_word(fetch_addr_i);
        rd_raw_o     = read_word(rd_addr_i);
    end

    // Control outputs
    assign init_rst_o  = init_rst_q;
    assign mwr_start_o = mwr_start_q;
    assign mwr_addr_o  = wdma_addr_q;
    assign mwr_len_o   = wdma_len_q;
    assign mwr_count_o = wdma_count_q;
    assign mwr_data_o  = wdma_pattern_q;
    assign mrd_start_o = mrd_start_q;
    assign mrd_addr_o  = rdma_addr_q;
    assign mrd_len_o   = rdma_len_q;
    assign mrd_count_o = rdma_count_q;

endmodule

//--- rtl/bmd_host_port.sv
// Host write queue with credit return, read-modify-write sequencer and read byte formatting
`timescale 1ns/100ps
`include "bmd_settings.svh"

module bmd_host_port (
    input  logic                       clk,
    input  logic                       rst_n,

    // Host write port, one credit per request
    input  logic                       wr_valid_i,
    input  bmd_access_pkg::reg_addr_t  wr_addr_i,
    input  bmd_access_pkg::byte_en_t   wr_be_i,
    input  bmd_access_pkg::data_word_t wr_data_i,
    output logic                       wr_credit_o,

    // Host read port
    input  bmd_access_pkg::byte_en_t   rd_be_i,
    input  bmd_access_pkg::data_word_t rd_raw_i,      // Stored word at the read address
    output bmd_access_pkg::data_word_t rd_data_o,

    // Register block
    output bmd_access_pkg::reg_addr_t  fetch_addr_o,
    input  bmd_access_pkg::data_word_t fetch_data_i,
    output logic                       commit_en_o,
    output bmd_access_pkg::reg_addr_t  commit_addr_o,
    output bmd_access_pkg::data_word_t commit_data_o
);

    import bmd_access_pkg::*;

    localparam int DEPTH = `BMD_WR_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Queue storage, indexed by the pointers below
    reg_addr_t  q_addr [DEPTH];
    byte_en_t   q_be   [DEPTH];
    data_word_t q_data [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_push;
    logic             q_pop;

    wr_state_e  state_q;
    wr_state_e  state_d;
    data_word_t fetched_q;
    data_word_t merged;

    logic       commit_en_q;
    reg_addr_t  commit_addr_q;
    data_word_t commit_data_q;

    // --------------------
    // Write queue
    // --------------------

    assign q_push = wr_valid_i;                 // Credits keep the queue from overflowing
    assign q_pop  = (state_q == WR_MERGE);      // Head leaves once merged

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_addr[wr_ptr] <= wr_addr_i;
            q_be[wr_ptr]   <= wr_be_i;
            q_data[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (q_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({q_push, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // --------------------
    // Sequencer
    // --------------------

    // A write arriving at an empty queue is fetched in the very next cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE:  state_d = (q_count != '0 || wr_valid_i) ? WR_FETCH : WR_IDLE;
            WR_FETCH: state_d = WR_MERGE;
            WR_MERGE: state_d = WR_IDLE;        // Commit lands before the next fetch
            default:  state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= WR_IDLE;
            commit_en_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            commit_en_q <= (state_q == WR_MERGE);
        end
    end

    assign fetch_addr_o = q_addr[rd_ptr];

    always_ff @(posedge clk) begin
        if (state_q == WR_FETCH) begin
            fetched_q <= fetch_data_i;          // Old word of the head entry
        end
        if (state_q == WR_MERGE) begin
            commit_addr_q <= q_addr[rd_ptr];
            commit_data_q <= merged;
        end
    end

    // Payload lanes run from the top byte down, storage from the bottom up
    always_comb begin
        for (int k = 0; k < `BMD_BE_W; k++) begin
            merged[BYTE_W*k +: BYTE_W] = q_be[rd_ptr][k] ?
                q_data[rd_ptr][`BMD_DATA_W-BYTE_W-BYTE_W*k +: BYTE_W] :
                fetched_q[BYTE_W*k +: BYTE_W];
        end
    end

    assign commit_en_o   = commit_en_q;
    assign commit_addr_o = commit_addr_q;
    assign commit_data_o = commit_data_q;
    assign wr_credit_o   = commit_en_q;         // One credit per committed write

    // --------------------
    // Read formatting
    // --------------------

    always_comb begin
        for (int k = 0; k < `BMD_BE_W; k++) begin
            rd_data_o[`BMD_DATA_W-BYTE_W-BYTE_W*k +: BYTE_W] =
                rd_be_i[k] ? rd_raw_i[BYTE_W*k +: BYTE_W] : '0;  // Masked lanes read zero
        end
    end

endmodule

//--- rtl/bmd_mem_access.sv
// Register access unit top level joining the host port and the DMA register block
`timescale 1ns/100ps

module bmd_mem_access (
    input  logic                       clk,
    input  logic                       rst_n,

    // Host write port
    input  logic                       wr_valid_i,
    input  bmd_access_pkg::reg_addr_t  wr_addr_i,
    input  bmd_access_pkg::byte_en_t   wr_be_i,
    input  bmd_access_pkg::data_word_t wr_data_i,
    output logic                       wr_credit_o,

    // Host read port
    input  bmd_access_pkg::reg_addr_t  rd_addr_i,
    input  bmd_access_pkg::byte_en_t   rd_be_i,
    output bmd_access_pkg::data_word_t rd_data_o,

    // DMA engine status
    input  logic                       mwr_done_i,
    input  logic                       mrd_done_i,

    // Control and descriptors
    output logic                       init_rst_o,
    output logic                       mwr_start_o,
    output bmd_access_pkg::data_word_t mwr_addr_o,
    output bmd_access_pkg::data_word_t mwr_len_o,
    output bmd_access_pkg::data_word_t mwr_count_o,
    output bmd_access_pkg::data_word_t mwr_data_o,
    output logic                       mrd_start_o,
    output bmd_access_pkg::data_word_t mrd_addr_o,
    output bmd_access_pkg::data_word_t mrd_len_o,
    output bmd_access_pkg::data_word_t mrd_count_o
);

    import bmd_access_pkg::*;

    reg_addr_t  fetch_addr;
    data_word_t fetch_data;
    logic       commit_en;
    reg_addr_t  commit_addr;
    data_word_t commit_data;
    data_word_t rd_raw;             // Unformatted word at rd_addr_i

    bmd_host_port u_host_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid_i    (wr_valid_i),
        .wr_addr_i     (wr_addr_i),
        .wr_be_i       (wr_be_i),
        .wr_data_i     (wr_data_i),
        .wr_credit_o   (wr_credit_o),
        .rd_be_i       (rd_be_i),
        .rd_raw_i      (rd_raw),
        .rd_data_o     (rd_data_o),
        .fetch_addr_o  (fetch_addr),
        .fetch_data_i  (fetch_data),
        .commit_en_o   (commit_en),
        .commit_addr_o (commit_addr),
        .commit_data_o (commit_data)
    );

    bmd_ctrl_regs u_ctrl_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_en_i   (commit_en),
        .commit_addr_i (commit_addr),
        .commit_data_i (commit_data),
        .fetch_addr_i  (fetch_addr),
        .fetch_data_o  (fetch_data),
        .rd_addr_i     (rd_addr_i),     // Second read port serves the host
        .rd_raw_o      (rd_raw),
        .mwr_done_i    (mwr_done_i),
        .mrd_done_i    (mrd_done_i),
        .init_rst_o    (init_rst_o),
        .mwr_start_o   (mwr_start_o),
        .mwr_addr_o    (mwr_addr_o),
        .mwr_len_o     (mwr_len_o),
        .mwr_count_o   (mwr_count_o),
        .mwr_data_o    (mwr_data_o),
        .mrd_start_o   (mrd_start_o),
        .mrd_addr_o    (mrd_addr_o),
        .mrd_len_o     (mrd_len_o),
        .mrd_count_o   (mrd_count_o)
    );

endmodule

//--- rtl/bmd_reg_pkg.sv
// Register map address enum and DCSR and DDMACR bit position type and constants
`include "bmd_settings.svh"

package bmd_reg_pkg;

    // --------------------
    // Register map
    // --------------------

    typedef enum logic [`BMD_ADDR_W-1:0] {
        REG_DCSR         = 0,   // Device control and status
        REG_DDMACR       = 1,   // DMA start and done bits
        REG_WDMA_ADDR    = 2,   // Write descriptor
        REG_WDMA_LEN     = 3,
        REG_WDMA_COUNT   = 4,
        REG_WDMA_PATTERN = 5,
        REG_RDMA_ADDR    = 6,   // Read descriptor
        REG_RDMA_LEN     = 7,
        REG_RDMA_COUNT   = 8
    } reg_addr_e;

    // --------------------
    // Bit positions
    // --------------------

    // Index of one bit inside a data word
    typedef logic [$clog2(`BMD_DATA_W)-1:0] bit_pos_t;

    // DCSR
    localparam bit_pos_t DCSR_INIT_RST = 0;     // Holds the DMA engines in reset
    localparam bit_pos_t DCSR_VER_LSB  = 24;    // Version byte, read only
    localparam bit_pos_t DCSR_VER_MSB  = 31;

    // DDMACR
    localparam bit_pos_t DDMACR_MWR_START = 0;  // Write engine start
    localparam bit_pos_t DDMACR_MWR_DONE  = 8;  // Sticky, read only
    localparam bit_pos_t DDMACR_MRD_START = 16; // Read engine start
    localparam bit_pos_t DDMACR_MRD_DONE  = 24; // Sticky, read only

endpackage

//--- sim.f
+incdir+include
rtl/bmd_reg_pkg.sv
rtl/bmd_access_pkg.sv
rtl/bmd_ctrl_regs.sv
rtl/bmd_host_port.sv
rtl/bmd_mem_access.sv
bench/mem_access_checker.sv
bench/mem_access_asserts.sv
bench/tb_mem_access.sv
